//--- common/bus_pkg.sv
// cpu bus types
// 68000 word address, i/o read-port vector, palette select,
// coin inputs and the status word seen by the sub cpu

package bus_pkg;

    // 68000 word address, a0 not on the bus
    typedef logic [23:1] cpu_addr_t;

    // read-port selects, one hot while a port is addressed
    typedef logic [2:0] io_rd_t;

    localparam int rd_cab = 0;   // cabinet i/o
    localparam int rd_sys = 1;   // system i/o
    localparam int rd_dip = 2;   // dip switches

    // palette select, only the low bank is mapped
    typedef logic [1:0] pal_sel_t;

    localparam int pal_lo = 0;   // first palette bank

    // coin inputs, one bit per slot
    typedef logic [1:0] coin_t;

    // sub cpu status word
    // bits 1:0 stay zero
    typedef logic [5:0] status_t;

    localparam int st_service = 5;   // service switch
    localparam int st_coin_hi = 4;   // coin 2
    localparam int st_coin_lo = 3;   // coin 1
    localparam int st_sec2    = 2;   // sec2 input

endpackage

//--- common/map_pkg.sv
// address map codes
// area, sub-region and offset codes of the fixed map,
// the protection window codes and the scrambler bank type

package map_pkg;

    // scrambler bank, picks one of four slot tables
    typedef logic [1:0] map_bank_t;

    // high area, addr[21:20]
    localparam logic [1:0] area_rom = 2'd0;   // program rom
    localparam logic [1:0] area_io  = 2'd3;   // fixed i/o area

    // scramble window, addr[21:18]
    localparam logic [3:0] scr_window = 4'd9;   // 0x24'0000

    // sub-regions of area 3, addr[19:14]
    localparam logic [5:0] sub_sysram = 6'd1;   // 0x30'4000
    localparam logic [5:0] sub_pal    = 6'd4;   // 0x31'0000
    localparam logic [5:0] sub_io     = 6'd5;   // 0x31'4000
    localparam logic [5:0] sub_prot   = 6'd7;   // 0x31'c000

    // offsets inside the i/o sub-region, addr[3:1]
    localparam logic [2:0] ofs_snd  = 3'd0;   // sound latch request
    localparam logic [2:0] ofs_prio = 3'd1;   // priority register
    localparam logic [2:0] ofs_dip  = 3'd4;
    localparam logic [2:0] ofs_cab  = 3'd5;
    localparam logic [2:0] ofs_sys  = 3'd6;

    // text layer and object blocks, addr[16:14]
    localparam logic [2:0] blk_txt = 3'd0;   // 0x30'0000
    localparam logic [2:0] blk_obj = 3'd2;   // 0x30'8000

    // text layer registers, addr[12:11]
    localparam logic [1:0] txt_ofs_mode  = 2'd0;
    localparam logic [1:0] txt_ofs_shift = 2'd1;
    localparam logic [1:0] txt_ofs_map   = 2'd2;

    // window slots, addr[15:13]
    localparam logic [2:0] slot_cnt_up = 3'd2;   // read steps the counter
    localparam logic [2:0] slot_clr    = 3'd5;   // write clears it

endpackage

//--- common/layer_sel_if.sv
// layer select bundle
// mode, shift and map selects of the background and
// foreground tilemap chips, as routed by the scrambler

`timescale 1ns/1ps

interface layer_sel_if;

    logic bg_mode;    // background control regs
    logic bg_shift;   // background scroll
    logic bg_map;     // background tile ram
    logic fg_mode;
    logic fg_shift;
    logic fg_map;

    // scrambler side
    modport producer (
        output bg_mode, bg_shift, bg_map,
        output fg_mode, fg_shift, fg_map
    );

    // merge side
    modport consumer (
        input bg_mode, bg_shift, bg_map,
        input fg_mode, fg_shift, fg_map
    );

endinterface

//--- decoder/fixed_map_decoder.sv
// fixed address decoder
// chip selects for every region whose location does not
// depend on the protection bank: rom, ram, palette, i/o,
// sound, priority, objects and the text layer chip
// all selects are combinational and low while as_n is high

`timescale 1ns/1ps

module fixed_map_decoder import bus_pkg::*, map_pkg::*; #(
    parameter int rom_banks = 8   // 64 KB rom blocks decoded
) (
    input  cpu_addr_t addr,
    input  logic      as_n,
    input  logic      rnw,
    output logic      rom_cs,
    output logic      sysram_cs,
    output pal_sel_t  pal_cs,
    output logic      snd_req,
    output logic      prio_cs,
    output io_rd_t    io_rd,
    output logic      prot_cs,
    output logic      obj_cs,
    output logic      txt_mode,
    output logic      txt_shift,
    output logic      txt_map
);

    // one extra bit so that 16 blocks still compare
    localparam logic [4:0] rom_lim = 5'(rom_banks);

    logic rom_area;   // area 0
    logic io_area;    // area 3
    logic txt_hit;    // text layer chip block

    assign rom_area = !as_n && addr[21:20] == area_rom;
    assign io_area  = !as_n && addr[21:20] == area_io;

    // not every socket is fitted, only the low blocks answer
    assign rom_cs = rom_area && rnw && {1'b0, addr[19:16]} < rom_lim;

    // text layer and objects, partial decode like the board
    assign txt_hit   = io_area && addr[16:14] == blk_txt;
    assign txt_mode  = txt_hit && addr[12:11] == txt_ofs_mode;
    assign txt_shift = txt_hit && addr[12:11] == txt_ofs_shift;
    assign txt_map   = txt_hit && addr[12:11] == txt_ofs_map;
    assign obj_cs    = io_area && addr[16:14] == blk_obj;   // object ram

    always_comb begin
        sysram_cs = 1'b0;
        pal_cs    = '0;   // bit 1 never decoded
        snd_req   = 1'b0;
        prio_cs   = 1'b0;
        io_rd     = '0;
        prot_cs   = 1'b0;
        if (io_area) begin
            case (addr[19:14])
                sub_sysram: sysram_cs = 1'b1;
                sub_pal:    pal_cs[pal_lo] = 1'b1;
                sub_io: begin
                    // port bank, word offsets
                    case (addr[3:1])
                        ofs_snd:  snd_req = 1'b1;
                        ofs_prio: prio_cs = 1'b1;
                        ofs_dip:  io_rd[rd_dip] = 1'b1;
                        ofs_cab:  io_rd[rd_cab] = 1'b1;
                        ofs_sys:  io_rd[rd_sys] = 1'b1;
                        default: ;   // unmapped ports
                    endcase
                end
                sub_prot:   prot_cs = 1'b1;   // protection area
                default: ;
            endcase
        end
    end

endmodule

//--- decoder/bank_scramble.sv
// protection scrambler
// reads of one window slot step a 2-bit counter and writes
// to another clear it. the count, latched while the bus is
// idle, picks which slot reaches which bg/fg register

`timescale 1ns/1ps

module bank_scramble import bus_pkg::*, map_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  cpu_addr_t addr,
    input  logic      as_n,
    input  logic      rnw,
    output logic      cnt_up,
    output logic      cnt_clr,
    layer_sel_if.producer layers
);

    map_bank_t  cnt;         // protection counter
    map_bank_t  bank;        // counter copy used for decode
    logic       cnt_up_l;    // last cycle's count-up select
    logic       cnt_clr_l;
    logic       in_win;      // inside 0x24'0000 window
    logic [2:0] slot;

    assign in_win  = !as_n && addr[21:18] == scr_window;
    assign slot    = addr[15:13];
    assign cnt_up  = in_win && slot == slot_cnt_up && rnw;    // read only
    assign cnt_clr = in_win && slot == slot_clr && !rnw;      // write only

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt       <= '0;
            bank      <= '0;
            cnt_up_l  <= 1'b0;
            cnt_clr_l <= 1'b0;
        end else begin
            cnt_up_l  <= cnt_up;
            cnt_clr_l <= cnt_clr;
            // act on select edges, held cycles count once
            if (cnt_clr && !cnt_clr_l)
                cnt <= '0;   // clear wins
            else if (cnt_up && !cnt_up_l)
                cnt <= cnt + 2'd1;
            if (as_n)
                bank <= cnt;   // only moves between bus cycles
        end
    end

    // slot to register tables
    always_comb begin
        layers.bg_mode  = 1'b0;
        layers.bg_shift = 1'b0;
        layers.bg_map   = 1'b0;
        layers.fg_mode  = 1'b0;
        layers.fg_shift = 1'b0;
        layers.fg_map   = 1'b0;
        if (in_win) begin
            case (bank)
                2'd0: begin
                    // plain layout, all six registers visible
                    layers.bg_mode  = slot == 3'd0;
                    layers.bg_shift = slot == 3'd1;
                    layers.bg_map   = slot == 3'd3;
                    layers.fg_mode  = slot == 3'd4;
                    layers.fg_shift = slot == 3'd6;
                    layers.fg_map   = slot == 3'd7;
                end
                2'd1: begin
                    layers.fg_map = slot == 3'd4;
                    layers.bg_map = slot == 3'd6;
                end
                2'd2: begin
                    layers.bg_map = slot == 3'd0;
                    layers.fg_map = slot == 3'd1 || slot == 3'd7;   // two aliases
                end
                default: begin   // bank 3
                    layers.fg_map = slot == 3'd0;
                    layers.bg_map = slot == 3'd4;
                end
            endcase
        end
    end

endmodule

//--- decoder/select_merge.sv
// select merge
// collects the scrambled layer selects and the text layer
// selects, forms the display summary, makes the per-frame
// object copy and vint clear strobes from vblank edges and
// builds the sub cpu status word

`timescale 1ns/1ps

module select_merge import bus_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    layer_sel_if.consumer layers,
    input  logic    txt_mode,
    input  logic    txt_shift,
    input  logic    txt_map,
    input  logic    lvbl,       // low during vblank
    input  logic    sec2,
    input  logic    service,
    input  coin_t   coin,
    output logic    bg_mode,
    output logic    bg_shift,
    output logic    bg_map,
    output logic    fg_mode,
    output logic    fg_shift,
    output logic    fg_map,
    output logic    txt_mode_cs,
    output logic    disp_cs,
    output logic    obj_copy,
    output logic    vint_clr,
    output status_t status
);

    logic lvbl_l;   // lvbl one clock ago

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            lvbl_l <= 1'b0;
        else
            lvbl_l <= lvbl;
    end

    // once per frame, no cpu register behind it
    assign obj_copy = !lvbl && lvbl_l;   // vblank starts
    assign vint_clr = lvbl && !lvbl_l;   // vblank ends

    assign bg_mode     = layers.bg_mode;
    assign bg_shift    = layers.bg_shift;
    assign bg_map      = layers.bg_map;
    assign fg_mode     = layers.fg_mode;
    assign fg_shift    = layers.fg_shift;
    assign fg_map      = layers.fg_map;
    assign txt_mode_cs = txt_mode;

    // any tile ram or scroll access of the three chips
    assign disp_cs = |{layers.bg_map, layers.fg_map, txt_map,
                       layers.bg_shift, layers.fg_shift, txt_shift};

    always_comb begin
        status                        = '0;   // bits 1:0 stay low
        status[st_service]            = service;
        status[st_coin_hi:st_coin_lo] = coin;
        status[st_sec2]               = sec2;
    end

endmodule

//--- design/cpu_map_top.sv
// cpu address map top
// main 68000 decoder of the three-tilemap board: fixed map
// decode, protection scrambler and the merge of both into
// display, strobe and status outputs

`timescale 1ns/1ps

module cpu_map_top import bus_pkg::*; #(
    parameter int rom_banks = 8
) (
    input  logic      clk,
    input  logic      rst,
    input  cpu_addr_t addr,
    input  logic      as_n,
    input  logic      rnw,
    input  logic      lvbl,
    input  logic      sec2,
    input  logic      service,
    input  coin_t     coin,
    output logic      rom_cs,
    output logic      sysram_cs,
    output pal_sel_t  pal_cs,
    output logic      snd_req,
    output logic      prio_cs,
    output io_rd_t    io_rd,
    output logic      prot_cs,
    output logic      obj_cs,
    output logic      cnt_up,
    output logic      cnt_clr,
    output logic      bg_mode,
    output logic      bg_shift,
    output logic      bg_map,
    output logic      fg_mode,
    output logic      fg_shift,
    output logic      fg_map,
    output logic      txt_mode_cs,
    output logic      disp_cs,
    output logic      obj_copy,
    output logic      vint_clr,
    output status_t   status
);

    logic txt_mode;    // text chip selects, fixed decode
    logic txt_shift;
    logic txt_map;

    layer_sel_if layers ();   // scrambled bg/fg selects

    fixed_map_decoder #(.rom_banks(rom_banks)) u_fixed (
        .addr, .as_n, .rnw,
        .rom_cs, .sysram_cs, .pal_cs, .snd_req, .prio_cs,
        .io_rd, .prot_cs, .obj_cs,
        .txt_mode, .txt_shift, .txt_map
    );

    bank_scramble u_scramble (
        .clk, .rst, .addr, .as_n, .rnw,
        .cnt_up, .cnt_clr,
        .layers (layers.producer)
    );

    select_merge u_merge (
        .clk, .rst,
        .layers (layers.consumer),
        .txt_mode, .txt_shift, .txt_map,
        .lvbl, .sec2, .service, .coin,
        .bg_mode, .bg_shift, .bg_map, .fg_mode, .fg_shift, .fg_map,
        .txt_mode_cs, .disp_cs, .obj_copy, .vint_clr, .status
    );

endmodule

//--- bench/tb_cpu_map.sv
// cpu map testbench
// directed tests of the fixed decode, the protection scrambler,
// the display summary, the vblank strobes and the status word,
// checked against a behavioral model of the address map

`timescale 1ns/1ps

module tb_cpu_map import bus_pkg::*, map_pkg::*; ();

    localparam int rom_blocks = 8;   // fitted rom blocks

    logic      clk;
    logic      rst;
    cpu_addr_t addr;
    logic      as_n, rnw, lvbl, sec2, service;
    coin_t     coin;
    logic      rom_cs, sysram_cs, snd_req, prio_cs, prot_cs, obj_cs;
    pal_sel_t  pal_cs;
    io_rd_t    io_rd;
    logic      cnt_up, cnt_clr, bg_mode, bg_shift, bg_map, fg_mode, fg_shift, fg_map;
    logic      txt_mode_cs, disp_cs, obj_copy, vint_clr;
    status_t   status;

    int        err_val;     // wrong values seen
    int        err_other;   // timeouts and the like

    map_bank_t m_cnt, m_bank;                   // model counter and bank
    logic      m_up, m_clr, m_up_l, m_clr_l, m_lvbl_l;

    cpu_map_top #(.rom_banks(rom_blocks)) u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        #100000;   // whole run is a few us
        abort_run("watchdog expired before the tests completed");
    end

    // model of the protection counter stepped by the select edges
    assign m_up  = !as_n && rnw && addr[21:18] == scr_window && addr[15:13] == slot_cnt_up;
    assign m_clr = !as_n && !rnw && addr[21:18] == scr_window && addr[15:13] == slot_clr;

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            {m_cnt, m_bank} <= '0;
            {m_up_l, m_clr_l, m_lvbl_l} <= '0;
        end else begin
            m_up_l   <= m_up;
            m_clr_l  <= m_clr;
            m_lvbl_l <= lvbl;
            if (m_clr && !m_clr_l)
                m_cnt <= 2'd0;
            else if (m_up && !m_up_l)
                m_cnt <= m_cnt + 2'd1;
            if (as_n)
                m_bank <= m_cnt;   // idle bus takes the new count
        end
    end

    // slot tables giving {bg_mode, bg_shift, bg_map, fg_mode, fg_shift, fg_map}
    function automatic logic [5:0] layer_table(input map_bank_t bank, input logic [2:0] slot);
        logic [5:0] f;
        case ({bank, slot})
            5'b00_000: f = 6'b100_000;
            5'b00_001: f = 6'b010_000;
            5'b00_011: f = 6'b001_000;
            5'b00_100: f = 6'b000_100;
            5'b00_110: f = 6'b000_010;
            5'b00_111: f = 6'b000_001;
            5'b01_100: f = 6'b000_001;   // bank 1
            5'b01_110: f = 6'b001_000;
            5'b10_000: f = 6'b001_000;   // bank 2
            5'b10_001, 5'b10_111: f = 6'b000_001;
            5'b11_000: f = 6'b000_001;   // bank 3
            5'b11_100: f = 6'b001_000;
            default:   f = 6'b000_000;
        endcase
        return f;
    endfunction

    function automatic cpu_addr_t win_addr(input logic [2:0] slot);
        logic [23:0] b;
        b = 24'h240000;   // byte address of the window
        b[15:13] = slot;
        return b[23:1];
    endfunction

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            err_val++;
            $display("ERROR %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    task automatic check_io(input string name, input io_rd_t expected, input io_rd_t actual);
        if (actual !== expected) begin
            err_val++;
            $display("ERROR %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    task automatic check_pal(input string name, input pal_sel_t expected, input pal_sel_t actual);
        if (actual !== expected) begin
            err_val++;
            $display("ERROR %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    task automatic check_status(input string name, input status_t expected,
                                input status_t actual);
        if (actual !== expected) begin
            err_val++;
            $display("ERROR %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    task automatic abort_run(input string why);
        err_other++;
        $display("%s", why);
        $display("errors: %0d wrong values, %0d other failures", err_val, err_other);
        $display("Finished with errors");
        $finish;
    endtask

    // every output against the model for the current bus state
    task automatic compare_all(input string name);
        logic       io_ar;
        logic       io_sub;
        logic       txt_blk;
        logic [5:0] lay;
        io_rd_t     e_io;
        io_ar   = !as_n && addr[21:20] == area_io;
        io_sub  = io_ar && addr[19:14] == sub_io;
        txt_blk = io_ar && addr[16:14] == blk_txt;
        lay     = '0;
        if (!as_n && addr[21:18] == scr_window)
            lay = layer_table(m_bank, addr[15:13]);
        e_io = {io_sub && addr[3:1] == ofs_dip, io_sub && addr[3:1] == ofs_sys,
                io_sub && addr[3:1] == ofs_cab};   // dip, sys, cab
        check_bit({name, " rom_cs"}, !as_n && rnw && addr[21:20] == area_rom
                  && int'(addr[19:16]) < rom_blocks, rom_cs);
        check_bit({name, " sysram_cs"}, io_ar && addr[19:14] == sub_sysram, sysram_cs);
        check_pal({name, " pal_cs"}, {1'b0, io_ar && addr[19:14] == sub_pal}, pal_cs);
        check_bit({name, " snd_req"}, io_sub && addr[3:1] == ofs_snd, snd_req);
        check_bit({name, " prio_cs"}, io_sub && addr[3:1] == ofs_prio, prio_cs);
        check_io({name, " io_rd"}, e_io, io_rd);
        check_bit({name, " prot_cs"}, io_ar && addr[19:14] == sub_prot, prot_cs);
        check_bit({name, " obj_cs"}, io_ar && addr[16:14] == blk_obj, obj_cs);
        check_bit({name, " cnt_up"}, m_up, cnt_up);
        check_bit({name, " cnt_clr"}, m_clr, cnt_clr);
        check_bit({name, " bg_mode"}, lay[5], bg_mode);
        check_bit({name, " bg_shift"}, lay[4], bg_shift);
        check_bit({name, " bg_map"}, lay[3], bg_map);
        check_bit({name, " fg_mode"}, lay[2], fg_mode);
        check_bit({name, " fg_shift"}, lay[1], fg_shift);
        check_bit({name, " fg_map"}, lay[0], fg_map);
        check_bit({name, " txt_mode_cs"}, txt_blk && addr[12:11] == txt_ofs_mode, txt_mode_cs);
        check_bit({name, " disp_cs"}, lay[4] || lay[3] || lay[1] || lay[0]
                  || (txt_blk && addr[12:11] == txt_ofs_shift)
                  || (txt_blk && addr[12:11] == txt_ofs_map), disp_cs);
        check_bit({name, " obj_copy"}, !lvbl && m_lvbl_l, obj_copy);
        check_bit({name, " vint_clr"}, lvbl && !m_lvbl_l, vint_clr);
    endtask

    // access held for some cycles and still driven 1 ns past its last edge
    task automatic bus_cycle(input cpu_addr_t a, input logic rd, input int cycles,
                             input string name);
        addr = a;
        rnw  = rd;
        as_n = 1'b0;
        repeat (cycles) begin
            #4;   // mid cycle where selects have settled
            compare_all(name);
            @(posedge clk);
            #1;
        end
    endtask

    task automatic idle(input string name);
        as_n = 1'b1;   // address left in place
        rnw  = 1'b1;
        #4;
        compare_all(name);
        @(posedge clk);
        #1;
    endtask

    task automatic sweep_window(input string name);
        for (int s = 0; s < 8; s++)
            bus_cycle(win_addr(3'(s)), 3'(s) == slot_clr, 1, name);   // neither counts nor clears
        idle({name, " idle"});
    endtask

    task automatic test_fixed_map();
        logic [23:0] regions [16];
        regions = '{24'h304000, 24'h310000, 24'h31c000, 24'h308000,
                    24'h300000, 24'h300800, 24'h301000, 24'h301800,
                    24'h314000, 24'h314002, 24'h314004, 24'h314006,
                    24'h314008, 24'h31400a, 24'h31400c, 24'h31400e};
        foreach (regions[i]) begin
            bus_cycle(regions[i][23:1], 1'b1, 1, "fixed read");
            bus_cycle(regions[i][23:1], 1'b0, 1, "fixed write");
            idle("fixed as_n high");
        end
    endtask

    task automatic test_rom();
        logic [23:0] b;
        for (int blk = 0; blk < 16; blk++) begin
            b = {4'h0, 4'(blk), 16'($urandom)};
            bus_cycle(b[23:1], 1'b1, 1, "rom read");
            check_bit("rom read block", blk < rom_blocks, rom_cs);
            bus_cycle(b[23:1], 1'b0, 1, "rom write");
            check_bit("rom write block", 1'b0, rom_cs);
            idle("rom idle");
        end
    endtask

    task automatic test_scramble();
        sweep_window("bank 0 sweep");
        for (int n = 1; n < 4; n++) begin
            bus_cycle(win_addr(slot_cnt_up), 1'b1, 1, "count up");
            idle("count idle");
            sweep_window("counted bank sweep");
        end
        bus_cycle(win_addr(3'd0), 1'b0, 1, "bank 3 slot 0");
        check_bit("bank 3 slot 0 fg_map", 1'b1, fg_map);
        bus_cycle(win_addr(slot_clr), 1'b0, 1, "pre-hold clear");
        idle("pre-hold idle");
        bus_cycle(win_addr(slot_cnt_up), 1'b1, 3, "held count up");
        idle("held idle");
        bus_cycle(win_addr(3'd4), 1'b0, 1, "held result");
        check_bit("held read bank 1 slot 4 fg_map", 1'b1, fg_map);
        sweep_window("bank 1 sweep");
    endtask

    task automatic test_clear();
        cpu_addr_t a;
        bus_cycle(win_addr(slot_cnt_up), 1'b1, 1, "clear count up");
        idle("clear count idle");
        bus_cycle(win_addr(slot_clr), 1'b0, 1, "clear write");
        idle("clear write idle");
        bus_cycle(win_addr(3'd0), 1'b0, 1, "after clear");
        check_bit("clear back to bank 0 bg_mode", 1'b1, bg_mode);
        for (int i = 0; i < 64; i++) begin
            a = 23'($urandom);
            a[21:18] = scr_window;
            bus_cycle(a, 1'($urandom), 1, "random window");
            if (1'($urandom))
                idle("random idle");
        end
        idle("random end");
    endtask

    task automatic count_strobes(input int cycles, output int n_obj, output int n_vint);
        n_obj  = 0;
        n_vint = 0;
        repeat (cycles) begin
            #4;
            compare_all("strobe watch");
            n_obj  += int'(obj_copy);
            n_vint += int'(vint_clr);
            @(posedge clk);
            #1;
        end
    endtask

    task automatic test_display();
        int n_obj;
        int n_vint;
        sweep_window("display sweep");
        lvbl = 1'b1;   // vblank ends
        count_strobes(6, n_obj, n_vint);
        check_bit("one vint_clr on lvbl rise", 1'b1, n_vint == 1);
        check_bit("no obj_copy on lvbl rise", 1'b1, n_obj == 0);
        lvbl = 1'b0;   // vblank starts
        count_strobes(6, n_obj, n_vint);
        check_bit("one obj_copy on lvbl fall", 1'b1, n_obj == 1);
        check_bit("no vint_clr on lvbl fall", 1'b1, n_vint == 0);
        count_strobes(6, n_obj, n_vint);   // steady lvbl
        check_bit("no strobes with steady lvbl", 1'b1, n_obj == 0 && n_vint == 0);
    endtask

    task automatic test_status();
        for (int i = 0; i < 16; i++) begin
            service = 1'($urandom);
            coin    = 2'($urandom);
            sec2    = 1'($urandom);
            #4;
            check_status("status word", {service, coin, sec2, 2'b00}, status);
            @(posedge clk);
            #1;
        end
    endtask

    initial begin
        err_val   = 0;
        err_other = 0;
        void'($urandom(32'h1076));   // one seed for the run
        rst       = 1'b1;
        addr      = '0;
        as_n      = 1'b1;
        rnw       = 1'b1;
        lvbl      = 1'b0;   // in vblank through reset
        sec2      = 1'b0;
        service   = 1'b0;
        coin      = '0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        idle("after reset");
        test_fixed_map();
        test_rom();
        test_scramble();
        test_clear();
        test_display();
        test_status();
        $display("errors: %0d wrong values, %0d other failures", err_val, err_other);
        if (err_val == 0 && err_other == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

//--- compile.f
common/bus_pkg.sv
common/map_pkg.sv
common/layer_sel_if.sv
decoder/fixed_map_decoder.sv
decoder/bank_scramble.sv
decoder/select_merge.sv
design/cpu_map_top.sv
bench/tb_cpu_map.sv

//--- Makefile
# Verilator build and run of the cpu map testbench

VERILATOR ?= verilator
TOP       ?= tb_cpu_map
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
PASS_MSG  ?= Finished with no errors

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
